/* verilog/elink_macros.svh */
`ifndef ELINK_MACROS_SVH
`define ELINK_MACROS_SVH

// ##############################
// packet format
// ##############################

// full emesh packet, write flag up to srcaddr
`define ELINK_PW 104

// register index width in the cfg space
`define ELINK_RFAW 6

// ##############################
// cfg space decode
// ##############################

`define ELINK_ID        12'h000  // matched against dstaddr[31:20]
`define ELINK_CFG_GROUP 3'h2     // matched against dstaddr[10:8]

// register indices, from dstaddr[RFAW+1:2]
`define E_RESET  6'd0
`define E_CLK    6'd1
`define E_CHIPID 6'd2

// reset values
`define ELINK_CLK_DEFAULT    16'h0573  // all clocks on, lowest speed
`define ELINK_CHIPID_DEFAULT 12'h808

// ##############################
// tx fifo
// ##############################

`define ELINK_FIFO_DEPTH 4
`define ELINK_FIFO_AW    2  // pointer width, log2 of depth

`endif

/* verilog/elink_pkg.sv */
`include "elink_macros.svh"

package elink_pkg;

   // ##############################
   // vector types
   // ##############################

   // bit 0 write, 2:1 datamode, 7:3 ctrlmode
   // 39:8 dstaddr, 71:40 data, 103:72 srcaddr
   typedef logic [`ELINK_PW-1:0] elink_packet_t;

   typedef logic [31:0] addr_t;     // mesh address
   typedef logic [31:0] data_t;     // one data word
   typedef logic [15:0] clk_cfg_t;  // pll clock setting
   typedef logic [11:0] chip_id_t;  // chip id

   // ##############################
   // emitter fsm
   // ##############################

   typedef enum logic [1:0] {
      idle,          // waiting for a packet and enable
      req_high,      // req up, waiting for ack
      wait_ack_low   // req down, waiting for ack to drop
   } emit_state_t;

endpackage

/* verilog/packet2emesh.sv */
// unpacks one emesh packet into its fields
// fixed layout, no logic beyond slicing

module packet2emesh (
   input  elink_pkg::elink_packet_t packet_in,
   output logic                     write_out,
   output logic [1:0]               datamode_out,
   output logic [4:0]               ctrlmode_out,
   output elink_pkg::addr_t         dstaddr_out,
   output elink_pkg::data_t         data_out,
   output elink_pkg::addr_t         srcaddr_out
);

   // ##############################
   // control fields
   // ##############################

   assign write_out    = packet_in[0];    // 1 = write
   assign datamode_out = packet_in[2:1];  // access size
   assign ctrlmode_out = packet_in[7:3];

   // ##############################
   // address and data
   // ##############################

   assign dstaddr_out = packet_in[39:8];
   assign data_out    = packet_in[71:40];   // write data
   assign srcaddr_out = packet_in[103:72];  // return addr for reads

endmodule

/* verilog/ecfg_elink.sv */
`include "elink_macros.svh"

// link config block
// catches cfg writes out of the tx write stream and
// holds link reset, pll clock setting and chip id

module ecfg_elink (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     txwr_access,        // one cycle strobe
   input  elink_pkg::elink_packet_t txwr_packet,
   output logic                     txwr_gated_access,  // strobe into tx fifo
   output logic                     elink_en,           // link master enable
   output elink_pkg::clk_cfg_t      clk_config,         // to pll
   output elink_pkg::chip_id_t      e_chipid
);

   logic                       mi_we;
   elink_pkg::addr_t           mi_addr;
   elink_pkg::data_t           mi_din;
   logic [`ELINK_RFAW-1:0]     reg_idx;
   logic                       cfg_hit;
   logic                       reset_write;
   logic                       clk_write;
   logic                       chipid_write;

   logic                       reset_reg;
   elink_pkg::clk_cfg_t        clk_reg;
   elink_pkg::chip_id_t        chipid_reg;

   // only write flag, address and data matter here
   packet2emesh u_p2e (
      .packet_in    (txwr_packet),
      .write_out    (mi_we),
      .datamode_out (),
      .ctrlmode_out (),
      .dstaddr_out  (mi_addr),
      .data_out     (mi_din),
      .srcaddr_out  ()
   );

   // ##############################
   // address decode
   // ##############################

   assign reg_idx = mi_addr[`ELINK_RFAW+1:2];  // word index

   assign cfg_hit = txwr_access & mi_we
                    & (mi_addr[31:20] == `ELINK_ID)
                    & (mi_addr[10:8] == `ELINK_CFG_GROUP);

   assign reset_write  = cfg_hit & (reg_idx == `E_RESET);
   assign clk_write    = cfg_hit & (reg_idx == `E_CLK);
   assign chipid_write = cfg_hit & (reg_idx == `E_CHIPID);

   // reads and unlisted indices still go to the link
   assign txwr_gated_access = txwr_access & ~(reset_write | clk_write | chipid_write);

   // ##############################
   // config registers
   // ##############################

   always_ff @(posedge clk) begin
      if (reset) begin
         reset_reg  <= 1'b0;  // link enabled out of reset
         clk_reg    <= `ELINK_CLK_DEFAULT;
         chipid_reg <= `ELINK_CHIPID_DEFAULT;
      end else begin
         if (reset_write)
            reset_reg <= mi_din[0];
         if (clk_write)
            clk_reg <= mi_din[15:0];
         if (chipid_write)
            chipid_reg <= mi_din[11:0];  // full 12 bits
      end
   end

   assign elink_en   = ~reset_reg;  // link held off while bit set
   assign clk_config = clk_reg;
   assign e_chipid   = chipid_reg;

endmodule

/* verilog/txwr_fifo.sv */
`include "elink_macros.svh"

// small packet fifo between cfg filter and emitter
// circular buffer, oldest entry always on rd_packet

module txwr_fifo (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     push,
   input  elink_pkg::elink_packet_t push_packet,
   input  logic                     pop,
   output elink_pkg::elink_packet_t rd_packet,
   output logic                     full,
   output logic                     empty
);

   elink_pkg::elink_packet_t    mem [`ELINK_FIFO_DEPTH];
   logic [`ELINK_FIFO_AW-1:0]   wr_ptr;
   logic [`ELINK_FIFO_AW-1:0]   rd_ptr;
   logic [`ELINK_FIFO_AW:0]     count;  // one extra bit to reach depth

   // ##############################
   // storage
   // ##############################

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= push_packet;
   end

   assign rd_packet = mem[rd_ptr];  // head of queue

   // ##############################
   // pointers and count
   // ##############################

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   // ##############################
   // flags
   // ##############################

   assign full  = (count == `ELINK_FIFO_DEPTH);
   assign empty = (count == '0);

endmodule

/* verilog/tx_emitter.sv */
// drains the tx fifo onto the outgoing link
// four phase req/ack, one packet per handshake

module tx_emitter (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     elink_en,
   input  logic                     fifo_empty,
   input  elink_pkg::elink_packet_t fifo_packet,
   output logic                     pop,
   output logic                     link_req,
   output elink_pkg::elink_packet_t link_packet,
   input  logic                     link_ack
);

   elink_pkg::emit_state_t   state;
   elink_pkg::elink_packet_t pkt_reg;  // held for whole handshake

   // new transfer only from idle and only while enabled
   assign pop = (state == elink_pkg::idle) & ~fifo_empty & elink_en;

   // ##############################
   // handshake fsm
   // ##############################

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= elink_pkg::idle;
      end else begin
         case (state)
            elink_pkg::idle: begin
               if (pop)
                  state <= elink_pkg::req_high;
            end
            elink_pkg::req_high: begin
               if (link_ack)
                  state <= elink_pkg::wait_ack_low;  // partner took it
            end
            elink_pkg::wait_ack_low: begin
               if (!link_ack)
                  state <= elink_pkg::idle;
            end
            default: state <= elink_pkg::idle;
         endcase
      end
   end

   // payload, loaded on the pop edge
   always_ff @(posedge clk) begin
      if (pop)
         pkt_reg <= fifo_packet;
   end

   // ##############################
   // link outputs
   // ##############################

   assign link_req    = (state == elink_pkg::req_high);
   assign link_packet = pkt_reg;  // stable until next pop

endmodule

/* verilog/elink_tx_top.sv */
// tx write entry path of the mesh link
// cfg filter, packet fifo, link emitter

module elink_tx_top (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     txwr_access,
   input  elink_pkg::elink_packet_t txwr_packet,
   output logic                     txwr_wait,    // fifo full
   output logic                     link_req,
   output elink_pkg::elink_packet_t link_packet,
   input  logic                     link_ack,
   output logic                     elink_en,
   output elink_pkg::clk_cfg_t      clk_config,
   output elink_pkg::chip_id_t      e_chipid
);

   logic                     txwr_gated_access;  // non cfg writes only
   logic                     fifo_pop;
   logic                     fifo_empty;
   elink_pkg::elink_packet_t fifo_packet;

   // ##############################
   // cfg filter
   // ##############################

   ecfg_elink u_ecfg (
      .clk               (clk),
      .reset             (reset),
      .txwr_access       (txwr_access),
      .txwr_packet       (txwr_packet),
      .txwr_gated_access (txwr_gated_access),
      .elink_en          (elink_en),
      .clk_config        (clk_config),
      .e_chipid          (e_chipid)
   );

   // ##############################
   // fifo and emitter
   // ##############################

   txwr_fifo u_fifo (
      .clk         (clk),
      .reset       (reset),
      .push        (txwr_gated_access),
      .push_packet (txwr_packet),
      .pop         (fifo_pop),
      .rd_packet   (fifo_packet),
      .full        (txwr_wait),  // back pressure to host
      .empty       (fifo_empty)
   );

   tx_emitter u_emit (
      .clk         (clk),
      .reset       (reset),
      .elink_en    (elink_en),
      .fifo_empty  (fifo_empty),
      .fifo_packet (fifo_packet),
      .pop         (fifo_pop),
      .link_req    (link_req),
      .link_packet (link_packet),
      .link_ack    (link_ack)
   );

endmodule

/* tb/elink_tx_assertions.sv */
module elink_tx_assertions (
   input logic                     clk,
   input logic                     reset,
   input logic                     txwr_access,
   input logic                     txwr_wait,
   input logic                     link_req,
   input logic                     link_ack,
   input elink_pkg::elink_packet_t link_packet
);

   // ##############################
   // four phase link
   // ##############################

   // req only falls after the partner acked
   req_until_ack: assert property (
      @(posedge clk) disable iff (reset) link_req && !link_ack |=> link_req
   ) else $error("link_req dropped before link_ack");

   packet_stable: assert property (
      @(posedge clk) disable iff (reset) link_req && $past(link_req) |-> $stable(link_packet)
   ) else $error("link_packet changed while link_req high");

   // host must hold off while fifo full
   no_access_on_wait: assert property (
      @(posedge clk) disable iff (reset) txwr_access |-> !txwr_wait
   ) else $error("txwr_access raised while txwr_wait high");

endmodule

bind elink_tx_top elink_tx_assertions u_assert (
   .clk         (clk),
   .reset       (reset),
   .txwr_access (txwr_access),
   .txwr_wait   (txwr_wait),
   .link_req    (link_req),
   .link_ack    (link_ack),
   .link_packet (link_packet)
);

/* tb/elink_tx_tb.sv */
module elink_tx_tb;

   logic                     clk;
   logic                     reset;
   logic                     txwr_access;
   elink_pkg::elink_packet_t txwr_packet;
   logic                     txwr_wait;
   logic                     link_req;
   elink_pkg::elink_packet_t link_packet;
   logic                     link_ack;
   logic                     elink_en;
   elink_pkg::clk_cfg_t      clk_config;
   elink_pkg::chip_id_t      e_chipid;

   string                    cmds [$];       // S and C lines in file order
   elink_pkg::elink_packet_t exp_pkts [$];   // link packets still due
   string                    exp_names [$];
   int                       link_count  = 0;  // packets seen on the link
   int                       cycle_count = 0;
   int                       cycle_limit = 0;  // 0 until golden file loaded
   logic [31:0]              lfsr;

   elink_tx_top u_dut (.*);

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // ##############################
   // helpers
   // ##############################

   // fibonacci, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_delay(output int d);
      logic [1:0] bits;
      lfsr = lfsr_step(lfsr);
      bits[1] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      bits[0] = lfsr[0];
      d = int'(bits);  // 0 to 3 cycles
   endtask

   task automatic step;
      @(posedge clk);
      #1;  // drive and sample just after the edge
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_packet(input string name, input elink_pkg::elink_packet_t exp,
                               input elink_pkg::elink_packet_t act);
      if (act !== exp)
         abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_clk(input string name, input elink_pkg::clk_cfg_t exp,
                            input elink_pkg::clk_cfg_t act);
      if (act !== exp)
         abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_chipid(input string name, input elink_pkg::chip_id_t exp,
                               input elink_pkg::chip_id_t act);
      if (act !== exp)
         abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_en(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
   endtask

   task automatic load_golden;
      int                       fd;
      int                       n_stim;
      string                    line;
      string                    name;
      string                    kind;
      elink_pkg::elink_packet_t pkt;
      n_stim = 0;
      fd = $fopen("tb/elink_tx_golden.txt", "r");
      if (fd == 0)
         abort_run("could not open tb/elink_tx_golden.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 3 || line[0] == "#")
            continue;  // blank or column notes
         void'($sscanf(line, "%s %s %h", name, kind, pkt));
         if (kind == "E") begin
            exp_names.push_back(name);
            exp_pkts.push_back(pkt);
         end else begin
            cmds.push_back(line);
            if (kind == "S")
               n_stim++;  // packets to send
         end
      end
      $fclose(fd);
      cycle_limit = (n_stim + exp_pkts.size()) * 16 + 200;
   endtask

   // ##############################
   // host side sender
   // ##############################

   initial begin
      string                    name;
      string                    kind;
      elink_pkg::elink_packet_t pkt;
      logic                     v_en;
      elink_pkg::clk_cfg_t      v_clk;
      elink_pkg::chip_id_t      v_chip;
      logic                     v_wait;
      int                       v_n;
      reset       = 1'b1;
      txwr_access = 1'b0;
      txwr_packet = '0;
      load_golden();
      repeat (3) step();
      reset = 1'b0;
      foreach (cmds[i]) begin
         void'($sscanf(cmds[i], "%s %s %h", name, kind, pkt));
         if (kind == "S") begin
            while (txwr_wait)
               step();  // back pressure
            txwr_packet = pkt;
            txwr_access = 1'b1;
            step();
            txwr_access = 1'b0;
         end else begin
            void'($sscanf(cmds[i], "%s %s %h %h %h %h %d", name, kind,
                          v_en, v_clk, v_chip, v_wait, v_n));
            while (link_count < v_n)
               step();
            repeat (6) step();  // settle, no extra packets allowed
            if (link_count != v_n)
               abort_run($sformatf("%s: %0d packets on the link, %0d due",
                                   name, link_count, v_n));
            check_en(name, v_en, elink_en);
            check_clk(name, v_clk, clk_config);
            check_chipid(name, v_chip, e_chipid);
            check_en({name, " txwr_wait"}, v_wait, txwr_wait);
         end
      end
      if (exp_pkts.size() != 0)
         abort_run($sformatf("%0d expected link packets never arrived", exp_pkts.size()));
      $display("Done: no errors");
      $finish;
   end

   // ##############################
   // link partner
   // ##############################

   initial begin
      int d;
      link_ack = 1'b0;
      lfsr     = 32'hf01ca4c3;
      forever begin
         step();
         if (link_req && !link_ack) begin  // new transfer
            if (exp_pkts.size() == 0)
               abort_run("a packet appeared on the link when none was expected");
            else
               check_packet(exp_names[0], exp_pkts[0], link_packet);
            void'(exp_pkts.pop_front());
            void'(exp_names.pop_front());
            link_count++;
            draw_delay(d);
            repeat (d) step();
            link_ack = 1'b1;
            do step(); while (link_req);  // wait for req to fall
            draw_delay(d);
            repeat (d) step();
            link_ack = 1'b0;
         end
      end
   end

   // run limit from the golden file length
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
         abort_run($sformatf("timeout after %0d cycles, the run did not finish", cycle_count));
   end

endmodule

/* tb/elink_tx_golden.txt */
# name kind values ; S = packet to send, E = packet due on link, in order
# C = en clk_config e_chipid txwr_wait link_count, packets are {src,data,dst,ctrl/mode/wr}
reset_vals C 1 0573 808 0 0
plain S 00001000112233448000010005
plain E 00001000112233448000010005
plain S 00002000000000000000020404
plain E 00002000000000000000020404
plain C 1 0573 808 0 2
cfg_write S 000000000000abcd0000020405
cfg_write S 00000000000001230000020805
cfg_write C 1 abcd 123 0 2
no_match S 00003000000011110010020405
no_match E 00003000000011110010020405
no_match S 00003000000022220000030405
no_match E 00003000000022220000030405
no_match S 00003000000033330000020c05
no_match E 00003000000033330000020c05
no_match C 1 abcd 123 0 5
link_off S 00000000000000010000020005
link_off S 00004000aaaa0001400000100d
link_off S 00004000aaaa0002400000140d
link_off S 00004000aaaa0003400000180d
link_off C 0 abcd 123 0 5
link_off S 00000000000000000000020005
link_off E 00004000aaaa0001400000100d
link_off E 00004000aaaa0002400000140d
link_off E 00004000aaaa0003400000180d
link_off C 1 abcd 123 0 8
fifo_full S 00000000000000010000020005
fifo_full S 00005000bbbb00015000000005
fifo_full S 00005000bbbb00025000000005
fifo_full S 00005000bbbb00035000000005
fifo_full S 00005000bbbb00045000000005
fifo_full C 0 abcd 123 1 8

/* sources.f */
+incdir+verilog
verilog/elink_pkg.sv
verilog/packet2emesh.sv
verilog/ecfg_elink.sv
verilog/txwr_fifo.sv
verilog/tx_emitter.sv
verilog/elink_tx_top.sv
tb/elink_tx_assertions.sv
tb/elink_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the elink tx testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module elink_tx_tb -f sources.f \
   -Mdir obj_dir -o elink_tx_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/elink_tx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
   echo "FAIL"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "FAIL: simulator exited with status $status"
   exit 1
fi
echo "PASS"
exit 0
